// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_sv32_dmmu -Mdir obj_dir -f filelist.f
	./obj_dir/Vtb_sv32_dmmu | tee $(LOG)
	grep -q "^ALL CHECKS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
hdl/sv32_mmu_pkg.sv
hdl/sv32_dtlb.sv
hdl/sv32_xlate_stage.sv
hdl/sv32_fault_check.sv
hdl/sv32_dmmu.sv
tb/sv32_dmmu_properties.sv
tb/sv32_dmmu_checker.sv
tb/tb_sv32_dmmu.sv

// ==== hdl/sv32_dmmu.sv ====
// Sv32 data MMU top level
// TLB lookup in the request cycle, then the request register and
// the permission check, answering one cycle after the request
`timescale 1ns/1ps
`default_nettype none

module sv32_dmmu
  import sv32_mmu_pkg::*;
#(
  parameter int unsigned DTLB_ENTRIES = 4
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            lsu_req_i,
  input  logic [VLEN-1:0] lsu_vaddr_i,
  input  logic            lsu_is_store_i,
  input  logic            en_translation_i,
  input  logic [1:0]      ld_st_priv_lvl_i,
  input  logic            sum_i,
  input  logic            flush_i,
  input  logic            refill_i,
  input  logic [VPNW-1:0] refill_vpn_i,
  input  logic [31:0]     refill_pte_i,
  input  logic            refill_mega_i,
  output logic            lsu_dtlb_hit_o,
  output logic [PPNW-1:0] lsu_dtlb_ppn_o,
  output logic            dtlb_miss_o,
  output logic            lsu_valid_o,
  output logic [PLEN-1:0] lsu_paddr_o,
  output logic            lsu_exc_valid_o,
  output logic [3:0]      lsu_exc_cause_o,
  output logic [VLEN-1:0] lsu_exc_tval_o
);

  logic            lu_hit;
  logic [31:0]     lu_pte;
  logic            lu_mega;
  logic            req_q;
  logic [VLEN-1:0] vaddr_q;
  logic            is_store_q;
  logic            hit_q;
  logic [31:0]     pte_q;

  // ------------------------------------------------------------
  // lookup stage
  // ------------------------------------------------------------
  sv32_dtlb #(
    .ENTRIES(DTLB_ENTRIES)
  ) dtlb_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .refill_i     (refill_i),
    .refill_vpn_i (refill_vpn_i),
    .refill_pte_i (refill_pte_i),
    .refill_mega_i(refill_mega_i),
    .lu_vaddr_i   (lsu_vaddr_i),
    .lu_hit_o     (lu_hit),
    .lu_pte_o     (lu_pte),
    .lu_mega_o    (lu_mega)
  );

  // register stage
  sv32_xlate_stage xlate_stage_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lsu_req_i       (lsu_req_i),
    .lsu_vaddr_i     (lsu_vaddr_i),
    .lsu_is_store_i  (lsu_is_store_i),
    .en_translation_i(en_translation_i),
    .lu_hit_i        (lu_hit),
    .lu_pte_i        (lu_pte),
    .lu_mega_i       (lu_mega),
    .req_q_o         (req_q),
    .vaddr_q_o       (vaddr_q),
    .is_store_q_o    (is_store_q),
    .hit_q_o         (hit_q),
    .pte_q_o         (pte_q),
    .paddr_o         (lsu_paddr_o),
    .dtlb_hit_o      (lsu_dtlb_hit_o),
    .dtlb_ppn_o      (lsu_dtlb_ppn_o),
    .dtlb_miss_o     (dtlb_miss_o)
  );

  // fault stage
  sv32_fault_check fault_check_i (
    .req_q_i         (req_q),
    .vaddr_q_i       (vaddr_q),
    .is_store_q_i    (is_store_q),
    .hit_q_i         (hit_q),
    .pte_q_i         (pte_q),
    .en_translation_i(en_translation_i),
    .ld_st_priv_lvl_i(ld_st_priv_lvl_i),
    .sum_i           (sum_i),
    .lsu_valid_o     (lsu_valid_o),
    .lsu_exc_valid_o (lsu_exc_valid_o),
    .lsu_exc_cause_o (lsu_exc_cause_o),
    .lsu_exc_tval_o  (lsu_exc_tval_o)
  );

endmodule

`default_nettype wire

// ==== hdl/sv32_dtlb.sv ====
// Sv32 data TLB
// fully associative, combinational lookup on the request address;
// entries are filled through a refill port with a round-robin victim
// and all of them are dropped on flush
`timescale 1ns/1ps
`default_nettype none

module sv32_dtlb
  import sv32_mmu_pkg::*;
#(
  parameter int unsigned ENTRIES = 4
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,
  input  logic            refill_i,
  input  logic [VPNW-1:0] refill_vpn_i,
  input  logic [31:0]     refill_pte_i,
  input  logic            refill_mega_i,
  input  sv32_vaddr_u     lu_vaddr_i,
  output logic            lu_hit_o,
  output logic [31:0]     lu_pte_o,
  output logic            lu_mega_o
);

  localparam int unsigned PTR_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  logic [ENTRIES-1:0][VPNW-1:0] tag_q;
  logic [ENTRIES-1:0][31:0]     pte_q;
  logic [ENTRIES-1:0]           mega_q;
  logic [ENTRIES-1:0]           valid_q;
  logic [ENTRIES-1:0]           match;
  logic [PTR_W-1:0]             ptr_q;
  logic                         refill_accept;

  // flush has priority over a refill in the same cycle
  assign refill_accept = refill_i & ~flush_i;

  // ------------------------------------------------------------
  // lookup
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < ENTRIES; i++) begin
      // megapage entries ignore vpn0
      match[i] = valid_q[i] &&
                 (tag_q[i][VPNW-1:VPNW/2] == lu_vaddr_i.page.vpn1) &&
                 (mega_q[i] || (tag_q[i][VPNW/2-1:0] == lu_vaddr_i.page.vpn0));
    end
  end

  // scan from the top so the lowest matching index is the one left
  always_comb begin
    lu_hit_o  = 1'b0;
    lu_pte_o  = '0;
    lu_mega_o = 1'b0;
    for (int i = ENTRIES - 1; i >= 0; i--) begin
      if (match[i]) begin
        lu_hit_o  = 1'b1;
        lu_pte_o  = pte_q[i];
        lu_mega_o = mega_q[i];
      end
    end
  end

  // ------------------------------------------------------------
  // valid bits and replacement pointer
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      ptr_q   <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (refill_i) begin
      valid_q[ptr_q] <= 1'b1;
      if (ptr_q == PTR_W'(ENTRIES - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= ptr_q + 1'b1;
      end
    end
  end

  // entry contents
  always_ff @(posedge clk_i) begin
    if (refill_accept) begin
      tag_q[ptr_q]  <= refill_vpn_i;
      pte_q[ptr_q]  <= refill_pte_i;
      mega_q[ptr_q] <= refill_mega_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/sv32_fault_check.sv ====
// Sv32 data permission check
// works on the registered request: raises the valid strobe and the
// load or store page fault from the PTE flags and privilege level
`timescale 1ns/1ps
`default_nettype none

module sv32_fault_check
  import sv32_mmu_pkg::*;
(
  input  logic            req_q_i,
  input  logic [VLEN-1:0] vaddr_q_i,
  input  logic            is_store_q_i,
  input  logic            hit_q_i,
  input  logic [31:0]     pte_q_i,
  input  logic            en_translation_i,
  input  logic [1:0]      ld_st_priv_lvl_i,
  input  logic            sum_i,
  output logic            lsu_valid_o,
  output logic            lsu_exc_valid_o,
  output logic [3:0]      lsu_exc_cause_o,
  output logic [VLEN-1:0] lsu_exc_tval_o
);

  logic access_err;
  logic store_fault;
  logic page_fault;
  logic xlate_hit;

  // a miss under translation is not answered at all
  assign lsu_valid_o = req_q_i & (~en_translation_i | hit_q_i);
  assign xlate_hit   = req_q_i & en_translation_i & hit_q_i;

  // S mode may touch U pages only with SUM set, U mode only U pages
  assign access_err = ((ld_st_priv_lvl_i == PRIV_S) && !sum_i && pte_q_i[PTE_U]) ||
                      ((ld_st_priv_lvl_i == PRIV_U) && !pte_q_i[PTE_U]);

  // stores also need a writable page that is already dirty
  assign store_fault = !pte_q_i[PTE_W] || access_err || !pte_q_i[PTE_D];

  assign page_fault = is_store_q_i ? store_fault : access_err;

  assign lsu_exc_valid_o = xlate_hit & page_fault;

  always_comb begin
    if (!lsu_exc_valid_o) begin
      lsu_exc_cause_o = '0;
    end else if (is_store_q_i) begin
      lsu_exc_cause_o = CAUSE_STORE_PF;
    end else begin
      lsu_exc_cause_o = CAUSE_LOAD_PF;
    end
  end

  assign lsu_exc_tval_o = vaddr_q_i;

endmodule

`default_nettype wire

// ==== hdl/sv32_mmu_pkg.sv ====
// Sv32 data MMU shared definitions
// address widths, PTE flag positions, privilege codes, page-fault
// causes and the two-way decoded virtual address
`default_nettype none

package sv32_mmu_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  localparam int unsigned VLEN      = 32;
  localparam int unsigned PLEN      = 34;
  localparam int unsigned PPNW      = 22;
  localparam int unsigned VPNW      = 20;
  localparam int unsigned PAGE_OFFS = 12;
  localparam int unsigned MEGA_OFFS = 22;

  // ------------------------------------------------------------
  // PTE flag bit positions, ppn sits in bits 31..10
  // ------------------------------------------------------------
  localparam int unsigned PTE_V = 0;
  localparam int unsigned PTE_R = 1;
  localparam int unsigned PTE_W = 2;
  localparam int unsigned PTE_X = 3;
  localparam int unsigned PTE_U = 4;
  localparam int unsigned PTE_G = 5;
  localparam int unsigned PTE_A = 6;
  localparam int unsigned PTE_D = 7;

  // privilege levels
  localparam logic [1:0] PRIV_U = 2'd0;
  localparam logic [1:0] PRIV_S = 2'd1;
  localparam logic [1:0] PRIV_M = 2'd3;

  // exception causes
  localparam logic [3:0] CAUSE_LOAD_PF  = 4'd13;
  localparam logic [3:0] CAUSE_STORE_PF = 4'd15;

  // virtual address, either as a 4 KiB page or as a 4 MiB megapage
  typedef union packed {
    struct packed {
      logic [VPNW/2-1:0]    vpn1;
      logic [VPNW/2-1:0]    vpn0;
      logic [PAGE_OFFS-1:0] offs;
    } page;
    struct packed {
      logic [VPNW/2-1:0]    vpn1;
      logic [MEGA_OFFS-1:0] offs;
    } mega;
  } sv32_vaddr_u;

endpackage

`default_nettype wire

// ==== hdl/sv32_xlate_stage.sv ====
// Sv32 translation register stage
// gives the early hit, ppn and miss strobe in the request cycle,
// registers the request with its lookup result and builds the
// physical address one cycle later
`timescale 1ns/1ps
`default_nettype none

module sv32_xlate_stage
  import sv32_mmu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            lsu_req_i,
  input  sv32_vaddr_u     lsu_vaddr_i,
  input  logic            lsu_is_store_i,
  input  logic            en_translation_i,
  input  logic            lu_hit_i,
  input  logic [31:0]     lu_pte_i,
  input  logic            lu_mega_i,
  output logic            req_q_o,
  output logic [VLEN-1:0] vaddr_q_o,
  output logic            is_store_q_o,
  output logic            hit_q_o,
  output logic [31:0]     pte_q_o,
  output logic [PLEN-1:0] paddr_o,
  output logic            dtlb_hit_o,
  output logic [PPNW-1:0] dtlb_ppn_o,
  output logic            dtlb_miss_o
);

  logic            req_q;
  logic            is_store_q;
  logic            hit_q;
  logic            mega_q;
  sv32_vaddr_u     vaddr_q;
  logic [31:0]     pte_q;
  logic [PPNW-1:0] lu_ppn;
  logic [PPNW-1:0] ppn_q;

  assign lu_ppn = lu_pte_i[31:32-PPNW];
  assign ppn_q  = pte_q[31:32-PPNW];

  // ------------------------------------------------------------
  // request cycle
  // ------------------------------------------------------------
  // always a hit with translation off
  assign dtlb_hit_o  = en_translation_i ? lu_hit_i : 1'b1;
  assign dtlb_miss_o = lsu_req_i & en_translation_i & ~lu_hit_i;

  always_comb begin
    if (!en_translation_i) begin
      dtlb_ppn_o = {{(PPNW-VPNW){1'b0}}, lsu_vaddr_i.page.vpn1, lsu_vaddr_i.page.vpn0};
    end else if (lu_mega_i) begin
      // megapage: low ppn bits come straight from vpn0
      dtlb_ppn_o = {lu_ppn[PPNW-1:VPNW/2], lsu_vaddr_i.page.vpn0};
    end else begin
      dtlb_ppn_o = lu_ppn;
    end
  end

  // ------------------------------------------------------------
  // request register
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q      <= 1'b0;
      is_store_q <= 1'b0;
      hit_q      <= 1'b0;
    end else begin
      req_q      <= lsu_req_i;
      is_store_q <= lsu_is_store_i;
      hit_q      <= lu_hit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    vaddr_q <= lsu_vaddr_i;
    pte_q   <= lu_pte_i;
    mega_q  <= lu_mega_i;
  end

  // physical address of the registered request
  always_comb begin
    if (!en_translation_i) begin
      paddr_o = {{(PLEN-VLEN){1'b0}}, vaddr_q};
    end else if (mega_q) begin
      paddr_o = {ppn_q[PPNW-1:VPNW/2], vaddr_q.mega.offs};
    end else begin
      paddr_o = {ppn_q, vaddr_q.page.offs};
    end
  end

  assign req_q_o      = req_q;
  assign vaddr_q_o    = vaddr_q;
  assign is_store_q_o = is_store_q;
  assign hit_q_o      = hit_q;
  assign pte_q_o      = pte_q;

endmodule

`default_nettype wire

// ==== tb/sv32_dmmu_checker.sv ====
// Sv32 data MMU response checker
// compares the early outputs in the request cycle and the registered
// response one cycle later with the expected values, counts errors
`timescale 1ns/1ps
`default_nettype none

module sv32_dmmu_checker
  import sv32_mmu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            chk_i,
  input  logic [127:0]    name_i,
  input  logic            exp_hit_i,
  input  logic [PPNW-1:0] exp_ppn_i,
  input  logic            exp_miss_i,
  input  logic            exp_valid_i,
  input  logic [PLEN-1:0] exp_paddr_i,
  input  logic            exp_exc_i,
  input  logic [3:0]      exp_cause_i,
  input  logic [VLEN-1:0] exp_tval_i,
  input  logic            hit_i,
  input  logic [PPNW-1:0] ppn_i,
  input  logic            miss_i,
  input  logic            valid_i,
  input  logic [PLEN-1:0] paddr_i,
  input  logic            exc_valid_i,
  input  logic [3:0]      exc_cause_i,
  input  logic [VLEN-1:0] exc_tval_i,
  output int              errors_o,
  output int              checks_o,
  output logic            pending_o
);

  logic            pend_q;
  logic [127:0]    name_q;
  logic            valid_q;
  logic [PLEN-1:0] paddr_q;
  logic            exc_q;
  logic [3:0]      cause_q;
  logic [VLEN-1:0] tval_q;
  int              errors = 0;
  int              checks = 0;

  task automatic check_value(input string field, input logic [33:0] exp,
                             input logic [33:0] act, input logic [127:0] name);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %0s %0s: expected %0h, actual %0h", name, field, exp, act);
    end
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
    end else begin
      // ----------------------------------------------------------
      // registered response of the request from the cycle before
      // ----------------------------------------------------------
      if (pend_q) begin
        check_value("valid", 34'(valid_q), 34'(valid_i), name_q);
        if (valid_q) begin
          check_value("paddr", 34'(paddr_q), 34'(paddr_i), name_q);
          check_value("exc", 34'(exc_q), 34'(exc_valid_i), name_q);
          if (exc_q) begin
            check_value("cause", 34'(cause_q), 34'(exc_cause_i), name_q);
            check_value("tval", 34'(tval_q), 34'(exc_tval_i), name_q);
          end
        end
      end else if (valid_i) begin
        errors++;
        $display("valid response seen with no request in the cycle before");
      end
      // early outputs of the request in this cycle
      if (chk_i) begin
        check_value("hit", 34'(exp_hit_i), 34'(hit_i), name_i);
        check_value("miss", 34'(exp_miss_i), 34'(miss_i), name_i);
        if (exp_hit_i) begin
          check_value("ppn", 34'(exp_ppn_i), 34'(ppn_i), name_i);
        end
      end
      pend_q  <= chk_i;
      name_q  <= name_i;
      valid_q <= exp_valid_i;
      paddr_q <= exp_paddr_i;
      exc_q   <= exp_exc_i;
      cause_q <= exp_cause_i;
      tval_q  <= exp_tval_i;
    end
  end

  assign errors_o  = errors;
  assign checks_o  = checks;
  assign pending_o = pend_q;

endmodule

`default_nettype wire

// ==== tb/sv32_dmmu_patterns.txt ====
# op: A access after an idle gap, B access on the next cycle, R refill, F flush
# op name vaddr st en priv sum rvpn rpte mega hit ppn miss valid paddr exc cause
A off_a      00001234 0 0 3 0 00000 00000000 0 1 000001 0 1 000001234 0 0
B off_b      fffff008 1 0 3 0 00000 00000000 0 1 0fffff 0 1 0fffff008 0 0
R r_page     00000000 0 0 0 0 12345 aaf34cd7 0 0 000000 0 0 000000000 0 0
A page_ld    12345abc 0 1 0 0 00000 00000000 0 1 2abcd3 0 1 2abcd3abc 0 0
B page_st    12345000 1 1 0 0 00000 00000000 0 1 2abcd3 0 1 2abcd3000 0 0
R r_mega     00000000 0 0 0 0 32000 5a63fcc7 1 0 000000 0 0 000000000 0 0
A mega_ld    32123456 0 1 1 0 00000 00000000 0 1 169923 0 1 169923456 0 0
B mega_st    323ffffc 1 1 1 0 00000 00000000 0 1 169bff 0 1 169bffffc 0 0
R r_ro       00000000 0 0 0 0 40001 00048cd3 0 0 000000 0 0 000000000 0 0
R r_clean    00000000 0 0 0 0 40002 00115857 0 0 000000 0 0 000000000 0 0
A st_ro      40001010 1 1 0 0 00000 00000000 0 1 000123 0 1 000123010 1 f
A st_clean   40002020 1 1 0 0 00000 00000000 0 1 000456 0 1 000456020 1 f
A ld_ro      40001030 0 1 0 0 00000 00000000 0 1 000123 0 1 000123030 0 0
A s_ld_nosum 40001040 0 1 1 0 00000 00000000 0 1 000123 0 1 000123040 1 d
A s_ld_sum   40001044 0 1 1 1 00000 00000000 0 1 000123 0 1 000123044 0 0
A u_ld_spage 32000100 0 1 0 0 00000 00000000 0 1 169800 0 1 169800100 1 d
A u_st_spage 32000200 1 1 0 0 00000 00000000 0 1 169800 0 1 169800200 1 f
A miss_ld    70000000 0 1 1 0 00000 00000000 0 0 000000 1 0 000000000 0 0
F flush      00000000 0 0 0 0 00000 00000000 0 0 000000 0 0 000000000 0 0
A flushed    12345abc 0 1 0 0 00000 00000000 0 0 000000 1 0 000000000 0 0
R r_page2    00000000 0 0 0 0 12345 aaf34cd7 0 0 000000 0 0 000000000 0 0
R r_mega2    00000000 0 0 0 0 32000 5a63fcc7 1 0 000000 0 0 000000000 0 0
A b2b_0      12345ffc 0 1 1 1 00000 00000000 0 1 2abcd3 0 1 2abcd3ffc 0 0
B b2b_1      32000004 1 1 1 1 00000 00000000 0 1 169800 0 1 169800004 0 0
B b2b_2      70000000 0 1 1 1 00000 00000000 0 0 000000 1 0 000000000 0 0
B b2b_3      12345008 1 1 1 1 00000 00000000 0 1 2abcd3 0 1 2abcd3008 0 0

// ==== tb/sv32_dmmu_properties.sv ====
// Sv32 data MMU response assertions
// bound to the top level, watches the response and miss strobes
`timescale 1ns/1ps
`default_nettype none

module sv32_dmmu_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic lsu_req_i,
  input logic lsu_dtlb_hit_i,
  input logic dtlb_miss_i,
  input logic lsu_valid_i,
  input logic lsu_exc_valid_i
);

  int unsigned fail_count = 0;

  a_exc_with_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_exc_valid_i |-> lsu_valid_i)
    else begin
      $error("exception raised without a valid response");
      fail_count++;
    end

  a_valid_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_valid_i |-> $past(lsu_req_i))
    else begin
      $error("valid response without a request in the cycle before");
      fail_count++;
    end

  a_miss_not_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dtlb_miss_i |-> !lsu_dtlb_hit_i)
    else begin
      $error("miss strobe together with the early hit");
      fail_count++;
    end

endmodule

bind sv32_dmmu sv32_dmmu_properties props_i (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .lsu_req_i      (lsu_req_i),
  .lsu_dtlb_hit_i (lsu_dtlb_hit_o),
  .dtlb_miss_i    (dtlb_miss_o),
  .lsu_valid_i    (lsu_valid_o),
  .lsu_exc_valid_i(lsu_exc_valid_o)
);

`default_nettype wire

// ==== tb/tb_sv32_dmmu.sv ====
// Sv32 data MMU testbench
// reads refill, flush and access operations from the pattern file,
// drives them on falling edges and hands the expected results to the
// checker
`timescale 1ns/1ps
`default_nettype none

module tb_sv32_dmmu
  import sv32_mmu_pkg::*;
();

  localparam int unsigned CLK_PERIOD      = 40;
  localparam int unsigned SEED            = 32'h9ae6_af92;
  localparam int unsigned TIMEOUT_CYCLES  = 20;
  localparam int unsigned WATCHDOG_CYCLES = 5000;

  logic clk, rst_n, lsu_req, lsu_is_store, en_translation, sum, flush, refill, refill_mega;
  logic [VLEN-1:0] lsu_vaddr, exc_tval, exp_tval;
  logic [1:0]      priv_lvl;
  logic [VPNW-1:0] refill_vpn, f_rvpn;
  logic [31:0]     refill_pte, f_vaddr, f_rpte;
  logic            dtlb_hit, dtlb_miss, lsu_valid, exc_valid, pending;
  logic [PPNW-1:0] dtlb_ppn, exp_ppn, f_ppn;
  logic [PLEN-1:0] lsu_paddr, exp_paddr, f_paddr;
  logic [3:0]      exc_cause, exp_cause, f_cause;
  logic            chk, exp_hit, exp_miss, exp_valid, exp_exc;
  logic [127:0]    exp_name, f_name;
  logic [7:0]      f_op;
  logic [1:0]      f_priv;
  logic            f_st, f_en, f_sum, f_mega, f_hit, f_miss, f_valid, f_exc;
  string           text_line;
  int              fd, n_patterns, tb_errors, chk_errors, chk_count;
  int unsigned     wait_cnt;

  sv32_dmmu #(.DTLB_ENTRIES(4)) sv32_dmmu_i (
    .clk_i(clk), .rst_ni(rst_n), .lsu_req_i(lsu_req), .lsu_vaddr_i(lsu_vaddr),
    .lsu_is_store_i(lsu_is_store), .en_translation_i(en_translation),
    .ld_st_priv_lvl_i(priv_lvl), .sum_i(sum), .flush_i(flush), .refill_i(refill),
    .refill_vpn_i(refill_vpn), .refill_pte_i(refill_pte), .refill_mega_i(refill_mega),
    .lsu_dtlb_hit_o(dtlb_hit), .lsu_dtlb_ppn_o(dtlb_ppn), .dtlb_miss_o(dtlb_miss),
    .lsu_valid_o(lsu_valid), .lsu_paddr_o(lsu_paddr), .lsu_exc_valid_o(exc_valid),
    .lsu_exc_cause_o(exc_cause), .lsu_exc_tval_o(exc_tval)
  );

  sv32_dmmu_checker checker_i (
    .clk_i(clk), .rst_ni(rst_n), .chk_i(chk), .name_i(exp_name), .exp_hit_i(exp_hit),
    .exp_ppn_i(exp_ppn), .exp_miss_i(exp_miss), .exp_valid_i(exp_valid),
    .exp_paddr_i(exp_paddr), .exp_exc_i(exp_exc), .exp_cause_i(exp_cause),
    .exp_tval_i(exp_tval), .hit_i(dtlb_hit), .ppn_i(dtlb_ppn), .miss_i(dtlb_miss),
    .valid_i(lsu_valid), .paddr_i(lsu_paddr), .exc_valid_i(exc_valid),
    .exc_cause_i(exc_cause), .exc_tval_i(exc_tval), .errors_o(chk_errors),
    .checks_o(chk_count), .pending_o(pending)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("simulation did not finish within the time limit");
    $display("CHECKS FAILED");
    $finish;
  end

  // strobes drop, translation mode and privilege stay as they are
  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(negedge clk);
      lsu_req = 1'b0;
      refill  = 1'b0;
      flush   = 1'b0;
      chk     = 1'b0;
    end
  endtask

  task automatic run_pattern();
    if (f_op != "B") begin
      idle_cycles($urandom_range(3, 1));
    end
    @(negedge clk);
    lsu_req = 1'b0;
    refill  = 1'b0;
    flush   = 1'b0;
    chk     = 1'b0;
    case (f_op)
      "R": begin
        refill      = 1'b1;
        refill_vpn  = f_rvpn;
        refill_pte  = f_rpte;
        refill_mega = f_mega;
      end
      "F": flush = 1'b1;
      "A", "B": begin
        lsu_req        = 1'b1;
        lsu_vaddr      = f_vaddr;
        lsu_is_store   = f_st;
        en_translation = f_en;
        priv_lvl       = f_priv;
        sum            = f_sum;
        chk            = 1'b1;
        exp_name       = f_name;
        exp_hit        = f_hit;
        exp_ppn        = f_ppn;
        exp_miss       = f_miss;
        exp_valid      = f_valid;
        exp_paddr      = f_paddr;
        exp_exc        = f_exc;
        exp_cause      = f_cause;
        exp_tval       = f_vaddr;
      end
      default: begin
        tb_errors++;
        $display("unknown operation in the pattern file: %0s", f_name);
      end
    endcase
  endtask

  initial begin
    {lsu_req, lsu_is_store, en_translation, sum, flush, refill, refill_mega} = '0;
    {lsu_vaddr, priv_lvl, refill_vpn, refill_pte} = '0;
    {chk, exp_hit, exp_miss, exp_valid, exp_exc, exp_ppn, exp_paddr} = '0;
    {exp_cause, exp_tval, exp_name} = '0;
    n_patterns = 0;
    tb_errors  = 0;
    void'($urandom(SEED));
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    wait_cnt = 0;
    while ((lsu_valid || dtlb_miss || exc_valid) && wait_cnt < TIMEOUT_CYCLES) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (wait_cnt >= TIMEOUT_CYCLES) begin
      tb_errors++;
      $display("DUT outputs did not go idle after reset");
    end

    fd = $fopen("tb/sv32_dmmu_patterns.txt", "r");
    if (fd == 0) begin
      tb_errors++;
      $display("cannot open the pattern file");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(text_line, fd) != 0) begin
          // comment and blank lines do not give all the fields
          if ($sscanf(text_line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f_op, f_name, f_vaddr, f_st, f_en, f_priv, f_sum, f_rvpn, f_rpte,
                      f_mega, f_hit, f_ppn, f_miss, f_valid, f_paddr, f_exc, f_cause) == 17) begin
            run_pattern();
            n_patterns++;
          end
        end
      end
      $fclose(fd);
    end
    if (n_patterns == 0) begin
      tb_errors++;
      $display("no operations were read from the pattern file");
    end

    idle_cycles(2);
    wait_cnt = 0;
    while (pending && wait_cnt < TIMEOUT_CYCLES) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (wait_cnt >= TIMEOUT_CYCLES) begin
      tb_errors++;
      $display("checker still waits for a response at the end of the run");
    end

    $display("patterns %0d, checks %0d, value errors %0d, assertion errors %0d, other errors %0d",
             n_patterns, chk_count, chk_errors, sv32_dmmu_i.props_i.fail_count, tb_errors);
    if (chk_errors == 0 && sv32_dmmu_i.props_i.fail_count == 0 && tb_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
